// ==== source/ram_reader_pkg.sv ====
`default_nettype none

package ram_reader_pkg;

  // ----------------------------------------------------------
  // burst geometry
  // ----------------------------------------------------------

  localparam int burst_len      = 16; // beats in every read burst.
  localparam int burst_len_log2 = 4;  // block number to word offset.

  // ----------------------------------------------------------
  // bus widths
  // ----------------------------------------------------------

  localparam int data_width = 64;
  localparam int byte_shift = 3;  // log2 of bytes per data word.
  localparam int addr_width = 32; // byte addresses.

  // ----------------------------------------------------------
  // read data channel
  // ----------------------------------------------------------

  // one beat as returned by the memory.
  typedef struct packed {
    logic [data_width-1:0] data;
    logic                  last; // final beat of the burst.
  } r_beat_t;

endpackage

`default_nettype wire

// ==== source/output_buffer.sv ====
`default_nettype none

module output_buffer
(
  input  wire                                   aclk,
  input  wire                                   aresetn,

  input  wire  [ram_reader_pkg::addr_width-1:0] in_data,
  input  wire                                   in_valid,
  output logic                                  in_ready,

  output logic [ram_reader_pkg::addr_width-1:0] out_data,
  output logic                                  out_valid,
  input  wire                                   out_ready
);

  import ram_reader_pkg::*;

  logic [addr_width-1:0] data_reg;
  logic                  valid_reg;
  logic                  load;

  // room when empty, or when the held word leaves this cycle.
  assign in_ready = ~valid_reg | out_ready;
  assign load     = in_valid & in_ready;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      valid_reg <= 1'b0;
    end
    else if (load)
    begin
      valid_reg <= 1'b1;
    end
    else if (out_ready)
    begin
      valid_reg <= 1'b0; // drained.
    end
  end

  always_ff @(posedge aclk)
  begin
    if (load)
    begin
      data_reg <= in_data; // held while stalled.
    end
  end

  assign out_data  = data_reg;
  assign out_valid = valid_reg;

endmodule

`default_nettype wire

// ==== source/stream_fifo.sv ====
`default_nettype none

module stream_fifo #
(
  parameter int fifo_depth = 64
)
(
  input  wire                                   aclk,
  input  wire                                   aresetn,

  input  wire                                   wr_en,
  input  wire  [ram_reader_pkg::data_width-1:0] wr_data,

  input  wire                                   rd_en,
  output logic [ram_reader_pkg::data_width-1:0] rd_data,
  output logic                                  empty,

  output logic [$clog2(fifo_depth):0]           count
);

  import ram_reader_pkg::*;

  localparam int ptr_width   = $clog2(fifo_depth);
  localparam int count_width = ptr_width + 1;

  logic [data_width-1:0] mem [fifo_depth];

  logic [ptr_width-1:0]   wr_ptr;
  logic [ptr_width-1:0]   rd_ptr;
  logic [count_width-1:0] fill;
  logic                   full;
  logic                   wr_ok;
  logic                   rd_ok;

  assign full  = (fill == count_width'(fifo_depth));
  assign empty = (fill == '0);

  assign wr_ok = wr_en & ~full;
  assign rd_ok = rd_en & ~empty;

  // ----------------------------------------------------------
  // storage
  // ----------------------------------------------------------

  always_ff @(posedge aclk)
  begin
    if (wr_ok)
    begin
      mem[wr_ptr] <= wr_data;
    end
  end

  assign rd_data = mem[rd_ptr]; // head word, no read latency.

  // ----------------------------------------------------------
  // pointers and fill level
  // ----------------------------------------------------------

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end
    else
    begin
      if (wr_ok)
      begin
        wr_ptr <= wr_ptr + 1'b1; // wraps at the depth.
      end

      if (rd_ok)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      case ({wr_ok, rd_ok})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  assign count = fill;

endmodule

`default_nettype wire

// ==== source/axis_ram_reader.sv ====
`default_nettype none

module axis_ram_reader #
(
  parameter int block_width = 16,
  parameter int fifo_depth  = 64
)
(
  input  wire                                   aclk,
  input  wire                                   aresetn,

  input  wire  [ram_reader_pkg::addr_width-1:0] min_addr,
  input  wire  [block_width-1:0]                cfg_data,
  output logic [block_width-1:0]                sts_data,

  output logic [ram_reader_pkg::addr_width-1:0] araddr,
  output logic                                  arvalid,
  input  wire                                   arready,

  input  wire  ram_reader_pkg::r_beat_t         rbeat,
  input  wire                                   rvalid,

  output logic [ram_reader_pkg::data_width-1:0] tdata,
  output logic                                  tvalid,
  input  wire                                   tready
);

  import ram_reader_pkg::*;

  localparam int count_width = $clog2(fifo_depth) + 1;
  localparam int block_shift = burst_len_log2 + byte_shift;

  logic [block_width-1:0] blk_cnt;
  logic                   req_pending; // address waiting for the slice.
  logic                   burst_busy;  // burst issued, last beat not yet seen.

  logic                   issue;
  logic                   req_valid;
  logic                   req_ready;
  logic [addr_width-1:0]  req_addr;

  logic                   fifo_empty;
  logic [count_width-1:0] fifo_count;

  // ----------------------------------------------------------
  // burst issue control
  // ----------------------------------------------------------

  // a whole burst must fit in the FIFO.
  assign issue = (fifo_count < count_width'(fifo_depth - burst_len + 1)) & ~burst_busy;

  assign req_valid = issue | req_pending;
  assign req_addr  = min_addr + (addr_width'(blk_cnt) << block_shift);

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      req_pending <= 1'b0;
      burst_busy  <= 1'b0;
      blk_cnt     <= '0;
    end
    else
    begin
      if (issue)
      begin
        req_pending <= 1'b1;
        burst_busy  <= 1'b1;
      end

      if (req_valid && req_ready)
      begin
        req_pending <= 1'b0;
        blk_cnt     <= (blk_cnt < cfg_data) ? blk_cnt + 1'b1 : '0; // wrap after cfg_data.
      end

      if (rvalid && rbeat.last)
      begin
        burst_busy <= 1'b0;
      end
    end
  end

  assign sts_data = blk_cnt;

  output_buffer buf_0
  (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_data   (req_addr),
    .in_valid  (req_valid),
    .in_ready  (req_ready),
    .out_data  (araddr),
    .out_valid (arvalid),
    .out_ready (arready)
  );

  // ----------------------------------------------------------
  // read data to stream
  // ----------------------------------------------------------

  stream_fifo #
  (
    .fifo_depth (fifo_depth)
  ) fifo_0
  (
    .aclk    (aclk),
    .aresetn (aresetn),
    .wr_en   (rvalid),     // every beat is taken.
    .wr_data (rbeat.data),
    .rd_en   (tready),
    .rd_data (tdata),
    .empty   (fifo_empty),
    .count   (fifo_count)
  );

  assign tvalid = ~fifo_empty;

endmodule

`default_nettype wire

// ==== source/axi_burst_ram.sv ====
`default_nettype none

module axi_burst_ram #
(
  parameter int mem_words_log2 = 12
)
(
  input  wire                                   aclk,
  input  wire                                   aresetn,

  input  wire  [ram_reader_pkg::addr_width-1:0] araddr,
  input  wire                                   arvalid,
  output logic                                  arready,

  output ram_reader_pkg::r_beat_t               rbeat,
  output logic                                  rvalid,

  input  wire                                   mem_we,
  input  wire  [mem_words_log2-1:0]             mem_waddr,
  input  wire  [ram_reader_pkg::data_width-1:0] mem_wdata
);

  import ram_reader_pkg::*;

  localparam int mem_words = 1 << mem_words_log2;
  localparam logic [burst_len_log2-1:0] last_beat = burst_len_log2'(burst_len - 1);

  logic [data_width-1:0] mem [mem_words];

  logic                      busy;     // burst in progress.
  logic                      ar_fire;
  logic [mem_words_log2-1:0] rd_addr;
  logic [burst_len_log2-1:0] beat_cnt;

  assign arready = ~busy;
  assign ar_fire = arvalid & ~busy;

  // ----------------------------------------------------------
  // memory array
  // ----------------------------------------------------------

  always_ff @(posedge aclk)
  begin
    if (mem_we)
    begin
      mem[mem_waddr] <= mem_wdata; // preload.
    end

    if (busy)
    begin
      rbeat.data <= mem[rd_addr];
      rbeat.last <= (beat_cnt == last_beat);
    end
  end

  // word address walks upward and wraps at the depth.
  always_ff @(posedge aclk)
  begin
    if (ar_fire)
    begin
      rd_addr <= araddr[byte_shift +: mem_words_log2];
    end
    else if (busy)
    begin
      rd_addr <= rd_addr + 1'b1;
    end
  end

  // ----------------------------------------------------------
  // burst sequencing
  // ----------------------------------------------------------

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      busy     <= 1'b0;
      rvalid   <= 1'b0;
      beat_cnt <= '0;
    end
    else
    begin
      rvalid <= busy; // one beat per busy cycle.

      if (ar_fire)
      begin
        busy     <= 1'b1;
        beat_cnt <= '0;
      end
      else if (busy)
      begin
        beat_cnt <= beat_cnt + 1'b1;

        if (beat_cnt == last_beat)
        begin
          busy <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/ram_reader_top.sv ====
`default_nettype none

module ram_reader_top #
(
  parameter int block_width    = 16,
  parameter int fifo_depth     = 64,
  parameter int mem_words_log2 = 12
)
(
  input  wire                                   aclk,
  input  wire                                   aresetn,

  input  wire  [ram_reader_pkg::addr_width-1:0] min_addr,
  input  wire  [block_width-1:0]                cfg_data,
  output logic [block_width-1:0]                sts_data,

  output logic [ram_reader_pkg::data_width-1:0] tdata,
  output logic                                  tvalid,
  input  wire                                   tready,

  input  wire                                   mem_we,
  input  wire  [mem_words_log2-1:0]             mem_waddr,
  input  wire  [ram_reader_pkg::data_width-1:0] mem_wdata
);

  import ram_reader_pkg::*;

  logic [addr_width-1:0] araddr;
  logic                  arvalid;
  logic                  arready;
  r_beat_t               rbeat;
  logic                  rvalid;

  axis_ram_reader #
  (
    .block_width (block_width),
    .fifo_depth  (fifo_depth)
  ) reader_0
  (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .min_addr (min_addr),
    .cfg_data (cfg_data),
    .sts_data (sts_data),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rbeat    (rbeat),
    .rvalid   (rvalid),
    .tdata    (tdata),
    .tvalid   (tvalid),
    .tready   (tready)
  );

  axi_burst_ram #
  (
    .mem_words_log2 (mem_words_log2)
  ) ram_0
  (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rbeat     (rbeat),
    .rvalid    (rvalid),
    .mem_we    (mem_we),
    .mem_waddr (mem_waddr),
    .mem_wdata (mem_wdata)
  );

endmodule

`default_nettype wire

// ==== test/tb_ram_reader.sv ====
`default_nettype none

module tb_ram_reader;

  import ram_reader_pkg::*;

  localparam int block_width    = 16;
  localparam int fifo_depth     = 64;
  localparam int mem_words_log2 = 12;
  localparam int mem_words      = 1 << mem_words_log2;

  // the reset test is split into two runs.
  localparam int total_words = 128 + 96 + 256 + 64 + 40 + 64;
  localparam int cycle_limit = 4 * total_words + 200;

  logic                      aclk = 1'b0;
  logic                      aresetn;
  logic [addr_width-1:0]     min_addr;
  logic [block_width-1:0]    cfg_data;
  logic [block_width-1:0]    sts_data;
  logic [data_width-1:0]     tdata;
  logic                      tvalid;
  logic                      tready = 1'b0;
  logic                      mem_we;
  logic [mem_words_log2-1:0] mem_waddr;
  logic [data_width-1:0]     mem_wdata;

  integer                    seed;
  logic                      ready_level = 1'b0;
  logic                      rand_ready  = 1'b0;
  logic                      run_active  = 1'b0;
  logic                      in_reset    = 1'b0;
  logic [block_width-1:0]    prev_sts    = '0;
  int                        rx_count    = 0;
  int                        err_count   = 0;
  int                        cycles      = 0;
  int                        words_done  = 0;
  int                        tests_done  = 0;

  ram_reader_top #
  (
    .block_width    (block_width),
    .fifo_depth     (fifo_depth),
    .mem_words_log2 (mem_words_log2)
  ) dut
  (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .min_addr  (min_addr),
    .cfg_data  (cfg_data),
    .sts_data  (sts_data),
    .tdata     (tdata),
    .tvalid    (tvalid),
    .tready    (tready),
    .mem_we    (mem_we),
    .mem_waddr (mem_waddr),
    .mem_wdata (mem_wdata)
  );

  always #2 aclk = ~aclk;

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------

  function automatic logic [data_width-1:0] pattern(input logic [mem_words_log2-1:0] a);
    logic [31:0] x;
    x = 32'(a);
    return {~x, x} ^ 64'h5a3c_96e1_0f1e_2d4b;
  endfunction

  function automatic logic [data_width-1:0] expected_word(input int k,
    input logic [addr_width-1:0] base, input logic [block_width-1:0] cfg);
    int          blk;
    logic [31:0] w;
    blk = (k / 16) % (int'(cfg) + 1); // block sequence wraps after cfg.
    w   = (base >> 3) + 32'(blk * 16) + 32'(k % 16);
    return pattern(w[mem_words_log2-1:0]); // modulo the RAM depth.
  endfunction

  // ----------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------

  always @(posedge aclk)
  begin : ready_drive
    logic [31:0] r;
    r = $random(seed);
    tready <= rand_ready ? (r[7:0] < 8'd102) : ready_level; // about 40% high.
  end

  task automatic apply_reset(input logic [addr_width-1:0] a, input logic [block_width-1:0] c);
    @(posedge aclk);
    aresetn     <= 1'b0;
    min_addr    <= a;
    cfg_data    <= c;
    ready_level <= 1'b0;
    rand_ready  <= 1'b0;
    repeat (3) @(posedge aclk);
    aresetn <= 1'b1;
  endtask

  task automatic wait_words(input int n);
    while (rx_count < n)
    begin
      @(posedge aclk);
    end
  endtask

  task automatic run_stream(input string name, input logic [addr_width-1:0] a,
    input logic [block_width-1:0] c, input int n, input int stall, input logic rnd);
    int e0;
    e0 = err_count;
    apply_reset(a, c);
    repeat (stall) @(posedge aclk); // FIFO fills while tready is low.
    ready_level <= 1'b1;
    rand_ready  <= rnd;
    wait_words(n);
    @(posedge aclk);
    tests_done = tests_done + 1;
    words_done = words_done + n;
    $display("test %0d %s: %0d words, %0d errors", tests_done, name, n, err_count - e0);
  endtask

  // ----------------------------------------------------------
  // monitor
  // ----------------------------------------------------------

  always @(posedge aclk)
  begin : monitor
    int                    e;
    logic [data_width-1:0] exp;
    e = 0;
    if (!aresetn)
    begin
      if (in_reset && tvalid !== 1'b0)
      begin
        $display("Error: tvalid during reset expected %h got %h", 1'b0, tvalid);
        e++;
      end
      rx_count <= 0;
      in_reset <= 1'b1;
    end
    else
    begin
      if (in_reset && sts_data !== '0)
      begin
        $display("Error: sts_data after reset expected %h got %h", 16'h0, sts_data);
        e++;
      end
      if (sts_data > cfg_data)
      begin
        $display("Error: sts_data expected at most %h got %h", cfg_data, sts_data);
        e++;
      end
      if (!in_reset && sts_data != prev_sts && sts_data != prev_sts + 1'b1 &&
          !(sts_data == '0 && prev_sts == cfg_data))
      begin
        $display("Error: sts_data expected %h or %h got %h", prev_sts + 1'b1, 16'h0, sts_data);
        e++;
      end
      if (tvalid && tready)
      begin
        exp = expected_word(rx_count, min_addr, cfg_data);
        if (tdata !== exp)
        begin
          $display("Error: tdata word %0d expected %h got %h", rx_count, exp, tdata);
          e++;
        end
        rx_count <= rx_count + 1;
      end
      in_reset <= 1'b0;
    end
    prev_sts  <= sts_data;
    err_count <= err_count + e;
  end

  always @(posedge aclk)
  begin
    if (run_active)
    begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit)
      begin
        $display("timeout after %0d cycles, the stream stopped delivering words", cycles);
        $display("Simulation failed");
        $finish;
      end
    end
  end

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------

  initial
  begin
    seed      = 32'h130b520d;
    aresetn   = 1'b0;
    min_addr  = '0;
    cfg_data  = '0;
    mem_we    = 1'b0;
    mem_waddr = '0;
    mem_wdata = '0;

    // preload every word while reset is held.
    for (int i = 0; i < mem_words; i++)
    begin
      @(posedge aclk);
      mem_we    <= 1'b1;
      mem_waddr <= mem_words_log2'(i);
      mem_wdata <= pattern(mem_words_log2'(i));
    end
    @(posedge aclk);
    mem_we     <= 1'b0;
    run_active <= 1'b1;

    run_stream("linear", 32'h0000_0000, 16'd7, 128, 0, 1'b0);
    run_stream("wrap", 32'h0000_3000, 16'd2, 96, 0, 1'b0);
    run_stream("backpressure", 32'h0000_7f00, 16'd9, 256, 80, 1'b1);
    run_stream("status", 32'h0000_0800, 16'd3, 64, 0, 1'b0);

    // stream is cut by a reset and restarts at a new base.
    run_stream("reset first half", 32'h0000_2000, 16'd5, 40, 0, 1'b0);
    run_stream("reset restart", 32'h0000_5000, 16'd5, 64, 0, 1'b0);

    repeat (2) @(posedge aclk);
    @(negedge aclk); // counts from the last edge have settled.
    $display("%0d tests, %0d words checked, %0d errors", tests_done, words_done, err_count);
    if (err_count == 0)
    begin
      $display("Simulation passed");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
source/ram_reader_pkg.sv
source/output_buffer.sv
source/stream_fifo.sv
source/axis_ram_reader.sv
source/axi_burst_ram.sv
source/ram_reader_top.sv
test/tb_ram_reader.sv

// ==== Makefile ====
# Verilator flow for the RAM reader.

VERILATOR ?= verilator
FILELIST  ?= list.f
TB_TOP    ?= tb_ram_reader
RTL_TOP   ?= ram_reader_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

SOURCES := $(wildcard source/*.sv) $(wildcard test/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
